// ==== icache.f ====
+incdir+tb
logic/icache_pkg.sv
logic/icache_pipeline.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_replacement.sv
logic/icache.sv
tb/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  --top-module icache_tb \
  -f icache.f \
  -o icache_sim
./obj_dir/icache_sim

// ==== tb/icache_tb_cases.svh ====
`ifndef ICACHE_TB_CASES_SVH
`define ICACHE_TB_CASES_SVH

typedef enum logic [2:0] {
  op_clear_all,
  op_fill,
  op_inval,
  op_fetch,
  op_poison
} row_kind_e;

// exp holds the expected replacement way 0..3 or one of these codes
localparam logic [2:0] exp_model_c = 3'd4;
localparam logic [2:0] exp_hit_c   = 3'd5;
localparam logic [2:0] exp_none_c  = 3'd6;

// kind, set index, way, physical tag, {word offset, half}, expected
typedef struct packed {
  row_kind_e  kind;
  index_t     index;
  way_t       way;
  ptag_t      ptag;
  logic [2:0] off;
  logic [2:0] exp;
} row_t;

localparam int n_rows_c = 23;

localparam row_t rows [n_rows_c] = '{
  '{op_clear_all, 4'd0, 2'd0, 28'h0000000, 3'd0, exp_none_c},
  '{op_fetch,     4'd3, 2'd0, 28'h1234567, 3'd0, 3'd0},
  '{op_fill,      4'd3, 2'd0, 28'h1234567, 3'd0, exp_none_c},
  '{op_fill,      4'd3, 2'd1, 28'h0abcdef, 3'd0, exp_none_c},
  '{op_fill,      4'd3, 2'd2, 28'h7654321, 3'd0, exp_none_c},
  '{op_fill,      4'd3, 2'd3, 28'h0000042, 3'd0, exp_none_c},
  '{op_fetch,     4'd3, 2'd0, 28'h1234567, 3'd0, exp_hit_c},
  '{op_fetch,     4'd3, 2'd0, 28'h1234567, 3'd5, exp_hit_c},
  '{op_fetch,     4'd3, 2'd1, 28'h0abcdef, 3'd2, exp_hit_c},
  '{op_fetch,     4'd3, 2'd1, 28'h0abcdef, 3'd5, exp_hit_c},
  '{op_fetch,     4'd3, 2'd2, 28'h7654321, 3'd4, exp_hit_c},
  '{op_fetch,     4'd3, 2'd2, 28'h7654321, 3'd7, exp_hit_c},
  '{op_fetch,     4'd3, 2'd3, 28'h0000042, 3'd6, exp_hit_c},
  '{op_fetch,     4'd3, 2'd3, 28'h0000042, 3'd1, exp_hit_c},
  '{op_fetch,     4'd3, 2'd1, 28'h0abcdef, 3'd0, exp_hit_c},
  '{op_fetch,     4'd3, 2'd0, 28'h0555555, 3'd0, exp_model_c},
  '{op_fill,      4'd5, 2'd0, 28'h0111111, 3'd0, exp_none_c},
  '{op_fill,      4'd5, 2'd1, 28'h0222222, 3'd0, exp_none_c},
  '{op_fetch,     4'd5, 2'd0, 28'h0333333, 3'd0, 3'd2},
  '{op_inval,     4'd5, 2'd0, 28'h0000000, 3'd0, exp_none_c},
  '{op_fetch,     4'd5, 2'd0, 28'h0333333, 3'd0, 3'd0},
  '{op_poison,    4'd3, 2'd0, 28'h1234567, 3'd0, exp_none_c},
  '{op_fetch,     4'd3, 2'd0, 28'h1234567, 3'd2, exp_hit_c}
};

// root 0 points at ways 0/1 and a leaf 0 points at the lower way
function automatic lru_t lru_after_hit(lru_t bits, way_t w);
  lru_t n;
  n = bits;
  n[0] = (w < 2) ? 1'b1 : 1'b0;
  if (w < 2) n[1] = (w == 0) ? 1'b1 : 1'b0;
  else n[2] = (w == 2) ? 1'b1 : 1'b0;
  return n;
endfunction

function automatic way_t lru_victim(lru_t bits);
  if (bits[0] == 1'b0) return bits[1] ? way_t'(1) : way_t'(0);
  return bits[2] ? way_t'(3) : way_t'(2);
endfunction

`endif

// ==== tb/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb
  import icache_pkg::*;
;

  `include "icache_tb_cases.svh"

  logic clk_i, reset_i;
  vaddr_t vaddr_i;
  logic vaddr_v_i, vaddr_ready_o;
  ptag_t ptag_i;
  logic ptag_v_i, poison_i;
  instr_t data_o;
  logic data_v_o, miss_o;
  logic cache_req_v_o, cache_req_ready_i, cache_req_complete_i;
  paddr_t cache_req_addr_o;
  way_t repl_way_o;
  logic repl_way_v_o;
  logic data_fill_v_i;
  index_t data_fill_index_i;
  way_t data_fill_way_i;
  block_t data_fill_block_i;
  logic tag_fill_v_i;
  tag_op_e tag_fill_op_i;
  index_t tag_fill_index_i;
  way_t tag_fill_way_i;
  tag_t tag_fill_tag_i;
  logic tag_fill_valid_i;
  logic fill_ready_o;

  block_t blocks [sets_c][ways_c];
  lru_t lru_model [sets_c];

  localparam int watchdog_cycles_c = n_rows_c * 40 + 16;

  icache dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    #(watchdog_cycles_c * 40);
    $display("Test failures found");
    $fatal(1, "timeout, the run did not finish in %0d cycles", watchdog_cycles_c);
  end

  task automatic compare(string name, logic [63:0] exp, logic [63:0] got);
    if (exp !== got) begin
      $display("[FAIL] %s exp=%h got=%h", name, exp, got);
      $display("Test failures found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic send_tag_op(tag_op_e op, index_t idx, way_t way, tag_t tag);
    @(negedge clk_i);
    tag_fill_v_i = 1'b1;
    tag_fill_op_i = op;
    tag_fill_index_i = idx;
    tag_fill_way_i = way;
    tag_fill_tag_i = tag;
    tag_fill_valid_i = 1'b1;
    compare("fill_ready_o", 1, fill_ready_o);
    @(negedge clk_i);
    tag_fill_v_i = 1'b0;
  endtask

  task automatic fill_block(index_t idx, way_t way, tag_t tag);
    block_t blk;
    for (int w = 0; w < ways_c; w++) begin
      blk[w*64 +: 64] = {$urandom, $urandom};
    end
    blocks[idx][way] = blk;
    data_fill_v_i = 1'b1;
    data_fill_index_i = idx;
    data_fill_way_i = way;
    data_fill_block_i = blk;
    send_tag_op(set_tag, idx, way, tag);
    data_fill_v_i = 1'b0;
  endtask

  // accept in one cycle, physical tag in the next, result after that
  task automatic drive_fetch(index_t idx, logic [2:0] off, ptag_t ptag, logic poison);
    @(negedge clk_i);
    compare("vaddr_ready_o", 1, vaddr_ready_o);
    vaddr_i = {30'd0, idx, off, 2'b00};
    vaddr_v_i = 1'b1;
    @(negedge clk_i);
    compare("fill_ready_o", 0, fill_ready_o);
    vaddr_v_i = 1'b0;
    ptag_i = ptag;
    ptag_v_i = 1'b1;
    poison_i = poison;
    @(negedge clk_i);
    ptag_v_i = 1'b0;
    poison_i = 1'b0;
  endtask

  task automatic finish_miss(way_t exp_way);
    @(negedge clk_i);
    compare("repl_way_v_o", 1, repl_way_v_o);
    compare("repl_way_o", exp_way, repl_way_o);
    compare("vaddr_ready_o", 0, vaddr_ready_o);
    compare("miss_o", 1, miss_o);
    @(negedge clk_i);
    compare("repl_way_v_o", 0, repl_way_v_o);
    compare("vaddr_ready_o", 0, vaddr_ready_o);
    cache_req_complete_i = 1'b1;
    @(negedge clk_i);
    cache_req_complete_i = 1'b0;
    compare("vaddr_ready_o", 1, vaddr_ready_o);
    compare("miss_o", 0, miss_o);
  endtask

  task automatic apply_row(row_t r);
    word_t word;
    way_t exp_way;
    case (r.kind)
      op_clear_all: begin
        for (int s = 0; s < sets_c; s++) begin
          send_tag_op(clear_set, index_t'(s), 2'd0, '0);
        end
      end
      op_fill: fill_block(r.index, r.way, {r.ptag, 3'b000});
      op_inval: send_tag_op(invalidate_way, r.index, r.way, '0);
      op_poison: begin
        drive_fetch(r.index, r.off, r.ptag, 1'b1);
        compare("data_v_o", 0, data_v_o);
        compare("miss_o", 0, miss_o);
        compare("cache_req_v_o", 0, cache_req_v_o);
      end
      default: begin
        drive_fetch(r.index, r.off, r.ptag, 1'b0);
        if (r.exp == exp_hit_c) begin
          word = blocks[r.index][r.way][r.off[2:1]*64 +: 64];
          compare("data_v_o", 1, data_v_o);
          compare("miss_o", 0, miss_o);
          compare("cache_req_v_o", 0, cache_req_v_o);
          compare("data_o", r.off[0] ? word[63:32] : word[31:0], data_o);
          lru_model[r.index] = lru_after_hit(lru_model[r.index], r.way);
        end else begin
          compare("data_v_o", 0, data_v_o);
          compare("miss_o", 1, miss_o);
          compare("cache_req_v_o", 1, cache_req_v_o);
          compare("cache_req_addr_o", {r.ptag, 3'b000, r.index, 5'd0}, cache_req_addr_o);
          exp_way = (r.exp == exp_model_c) ? lru_victim(lru_model[r.index]) : r.exp[1:0];
          finish_miss(exp_way);
        end
      end
    endcase
  endtask

  initial begin
    void'($urandom(88020));
    reset_i = 1'b1;
    vaddr_i = '0;
    vaddr_v_i = 1'b0;
    ptag_i = '0;
    ptag_v_i = 1'b0;
    poison_i = 1'b0;
    cache_req_ready_i = 1'b1;
    cache_req_complete_i = 1'b0;
    data_fill_v_i = 1'b0;
    data_fill_index_i = '0;
    data_fill_way_i = '0;
    data_fill_block_i = '0;
    tag_fill_v_i = 1'b0;
    tag_fill_op_i = clear_set;
    tag_fill_index_i = '0;
    tag_fill_way_i = '0;
    tag_fill_tag_i = '0;
    tag_fill_valid_i = 1'b0;
    for (int s = 0; s < sets_c; s++) begin
      lru_model[s] = '0;
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int i = 0; i < n_rows_c; i++) begin
      apply_row(rows[i]);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== logic/icache.sv ====
`timescale 1ns/1ps

module icache
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,

  input  vaddr_t   vaddr_i,
  input  logic     vaddr_v_i,
  output logic     vaddr_ready_o,

  input  ptag_t    ptag_i,
  input  logic     ptag_v_i,
  input  logic     poison_i,

  output instr_t   data_o,
  output logic     data_v_o,
  output logic     miss_o,

  output logic     cache_req_v_o,
  output paddr_t   cache_req_addr_o,
  input  logic     cache_req_ready_i,
  input  logic     cache_req_complete_i,

  output way_t     repl_way_o,
  output logic     repl_way_v_o,

  input  logic     data_fill_v_i,
  input  index_t   data_fill_index_i,
  input  way_t     data_fill_way_i,
  input  block_t   data_fill_block_i,

  input  logic     tag_fill_v_i,
  input  tag_op_e  tag_fill_op_i,
  input  index_t   tag_fill_index_i,
  input  way_t     tag_fill_way_i,
  input  tag_t     tag_fill_tag_i,
  input  logic     tag_fill_valid_i,

  output logic     fill_ready_o
);

  logic               lookup;
  tag_t  [ways_c-1:0] tags;
  logic  [ways_c-1:0] valid;
  word_t [ways_c-1:0] words;
  logic               hit;
  way_t               hit_way;
  index_t             tv_index;
  logic  [ways_c-1:0] tv_valid;

  // a fetch lookup owns both arrays for its cycle
  assign fill_ready_o = ~lookup;

  icache_pipeline pipeline (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .vaddr_i              (vaddr_i),
    .vaddr_v_i            (vaddr_v_i),
    .vaddr_ready_o        (vaddr_ready_o),
    .ptag_i               (ptag_i),
    .ptag_v_i             (ptag_v_i),
    .poison_i             (poison_i),
    .data_o               (data_o),
    .data_v_o             (data_v_o),
    .miss_o               (miss_o),
    .cache_req_v_o        (cache_req_v_o),
    .cache_req_addr_o     (cache_req_addr_o),
    .cache_req_ready_i    (cache_req_ready_i),
    .cache_req_complete_i (cache_req_complete_i),
    .lookup_o             (lookup),
    .tags_i               (tags),
    .valid_i              (valid),
    .words_i              (words),
    .hit_o                (hit),
    .hit_way_o            (hit_way),
    .tv_index_o           (tv_index),
    .tv_valid_o           (tv_valid)
  );

  icache_tag_array tag_array (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .lookup_i         (lookup),
    .lookup_index_i   (vaddr_i[block_offset_width_c +: index_width_c]),
    .tag_fill_v_i     (tag_fill_v_i),
    .tag_fill_op_i    (tag_fill_op_i),
    .tag_fill_index_i (tag_fill_index_i),
    .tag_fill_way_i   (tag_fill_way_i),
    .tag_fill_tag_i   (tag_fill_tag_i),
    .tag_fill_valid_i (tag_fill_valid_i),
    .tags_o           (tags),
    .valid_o          (valid)
  );

  icache_data_array data_array (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .lookup_i          (lookup),
    .lookup_index_i    (vaddr_i[block_offset_width_c +: index_width_c]),
    .lookup_offset_i   (vaddr_i[byte_offset_width_c +: word_offset_width_c]),
    .data_fill_v_i     (data_fill_v_i),
    .data_fill_index_i (data_fill_index_i),
    .data_fill_way_i   (data_fill_way_i),
    .data_fill_block_i (data_fill_block_i),
    .words_o           (words)
  );

  icache_replacement replacement (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .hit_i         (hit),
    .hit_way_i     (hit_way),
    .tv_index_i    (tv_index),
    .valid_i       (tv_valid),
    .cache_req_v_i (cache_req_v_o),
    .repl_way_o    (repl_way_o),
    .repl_way_v_o  (repl_way_v_o)
  );

endmodule

// ==== logic/icache_replacement.sv ====
`timescale 1ns/1ps

module icache_replacement
  import icache_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,

  input  logic              hit_i,
  input  way_t              hit_way_i,
  input  index_t            tv_index_i,
  input  logic [ways_c-1:0] valid_i,

  input  logic              cache_req_v_i,
  output way_t              repl_way_o,
  output logic              repl_way_v_o
);

  lru_t lru_r [sets_c];
  lru_t lru_cur;
  lru_t lru_next;
  way_t lru_way;
  way_t invalid_way;
  logic invalid_exist;

  assign lru_cur = lru_r[tv_index_i];

  // bit 0 root, bit 1 leaf of ways 0/1, bit 2 leaf of ways 2/3
  always_comb begin
    lru_next    = lru_cur;
    lru_next[0] = ~hit_way_i[1];
    if (hit_way_i[1]) begin
      lru_next[2] = ~hit_way_i[0];
    end else begin
      lru_next[1] = ~hit_way_i[0];
    end
  end

  assign lru_way = lru_cur[0] ? {1'b1, lru_cur[2]} : {1'b0, lru_cur[1]};

  // first invalid way
  always_comb begin
    invalid_way = '0;
    for (int i = ways_c - 1; i >= 0; i--) begin
      if (!valid_i[i]) begin
        invalid_way = way_t'(i);
      end
    end
  end

  assign invalid_exist = ~&valid_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_c; s++) begin
        lru_r[s] <= '0;
      end
    end else if (hit_i) begin
      lru_r[tv_index_i] <= lru_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      repl_way_v_o <= 1'b0;
    end else begin
      repl_way_v_o <= cache_req_v_i;
    end
  end

  // invalid ways are refilled before any valid one is evicted
  always_ff @(posedge clk_i) begin
    if (cache_req_v_i) begin
      repl_way_o <= invalid_exist ? invalid_way : lru_way;
    end
  end

endmodule

// ==== logic/icache_data_array.sv ====
`timescale 1ns/1ps

module icache_data_array
  import icache_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               lookup_i,
  input  index_t             lookup_index_i,
  input  word_offset_t       lookup_offset_i,

  input  logic               data_fill_v_i,
  input  index_t             data_fill_index_i,
  input  way_t               data_fill_way_i,
  input  block_t             data_fill_block_i,

  output word_t [ways_c-1:0] words_o
);

  localparam int bank_depth_c = sets_c * ways_c;

  typedef logic [index_width_c+word_offset_width_c-1:0] bank_addr_t;

  word_t                     bank_mem [ways_c][bank_depth_c];
  word_t                     rd_word_r [ways_c];
  logic                      fill_we;
  bank_addr_t                lookup_addr;
  word_offset_t [ways_c-1:0] fill_slot;
  word_t        [ways_c-1:0] fill_words;

  assign fill_we     = data_fill_v_i & ~lookup_i & ~reset_i;
  assign lookup_addr = {lookup_index_i, lookup_offset_i};

  // word w of way v sits in bank v^w at slot w
  for (genvar b = 0; b < ways_c; b++) begin : g_bank
    assign fill_slot[b]  = data_fill_way_i ^ word_offset_t'(b);
    assign fill_words[b] = data_fill_block_i[fill_slot[b]*word_width_c +: word_width_c];

    always_ff @(posedge clk_i) begin
      if (!reset_i && lookup_i) begin
        // bank b returns way b^offset
        rd_word_r[b] <= bank_mem[b][lookup_addr];
      end else if (fill_we) begin
        bank_mem[b][{data_fill_index_i, fill_slot[b]}] <= fill_words[b];
      end
    end

    assign words_o[b] = rd_word_r[b];
  end

endmodule

// ==== logic/icache_tag_array.sv ====
`timescale 1ns/1ps

module icache_tag_array
  import icache_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               lookup_i,
  input  index_t             lookup_index_i,

  input  logic               tag_fill_v_i,
  input  tag_op_e            tag_fill_op_i,
  input  index_t             tag_fill_index_i,
  input  way_t               tag_fill_way_i,
  input  tag_t               tag_fill_tag_i,
  input  logic               tag_fill_valid_i,

  output tag_t [ways_c-1:0]  tags_o,
  output logic [ways_c-1:0]  valid_o
);

  tag_t [ways_c-1:0] tag_mem   [sets_c];
  logic [ways_c-1:0] valid_mem [sets_c];
  logic              fill_we;

  // lookup has priority over fill
  assign fill_we = tag_fill_v_i & ~lookup_i & ~reset_i;

  // read the whole set
  always_ff @(posedge clk_i) begin
    if (!reset_i && lookup_i) begin
      tags_o  <= tag_mem[lookup_index_i];
      valid_o <= valid_mem[lookup_index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_we) begin
      case (tag_fill_op_i)
        clear_set: begin
          valid_mem[tag_fill_index_i] <= '0;
        end
        invalidate_way: begin
          valid_mem[tag_fill_index_i][tag_fill_way_i] <= 1'b0;
        end
        set_tag: begin
          tag_mem[tag_fill_index_i][tag_fill_way_i]   <= tag_fill_tag_i;
          valid_mem[tag_fill_index_i][tag_fill_way_i] <= tag_fill_valid_i;
        end
        default: begin
          // unused opcode, no write
        end
      endcase
    end
  end

  // the fourth opcode encoding has no meaning
  assert property (@(posedge clk_i) disable iff (reset_i)
    fill_we |-> tag_fill_op_i inside {clear_set, invalidate_way, set_tag})
    else $error("undefined tag fill opcode %0d", tag_fill_op_i);

endmodule

// ==== logic/icache_pipeline.sv ====
`timescale 1ns/1ps

module icache_pipeline
  import icache_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,

  input  vaddr_t             vaddr_i,
  input  logic               vaddr_v_i,
  output logic               vaddr_ready_o,
  input  ptag_t              ptag_i,
  input  logic               ptag_v_i,
  input  logic               poison_i,

  output instr_t             data_o,
  output logic               data_v_o,
  output logic               miss_o,

  output logic               cache_req_v_o,
  output paddr_t             cache_req_addr_o,
  input  logic               cache_req_ready_i,
  input  logic               cache_req_complete_i,

  output logic               lookup_o,
  input  tag_t  [ways_c-1:0] tags_i,
  input  logic  [ways_c-1:0] valid_i,
  input  word_t [ways_c-1:0] words_i,

  output logic               hit_o,
  output way_t               hit_way_o,
  output index_t             tv_index_o,
  output logic  [ways_c-1:0] tv_valid_o
);

  logic               tl_we;
  logic               v_tl_r;
  vaddr_t             vaddr_tl_r;

  logic               tv_we;
  logic               v_tv_r;
  paddr_t             paddr_tv_r;
  tag_t  [ways_c-1:0] tags_tv_r;
  logic  [ways_c-1:0] valid_tv_r;
  word_t [ways_c-1:0] words_tv_r;

  tag_t               addr_tag_tv;
  word_offset_t       offset_tv;
  logic  [ways_c-1:0] hit_v;
  logic               hit_any;
  way_t               hit_way;
  word_t              word_picked;
  logic               miss_tv;
  logic               miss_tracker_r;

  // TL stage
  assign tl_we    = vaddr_v_i & cache_req_ready_i;
  assign lookup_o = tl_we;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
    end else begin
      v_tl_r <= tl_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_we) begin
      vaddr_tl_r <= vaddr_i;
    end
  end

  // TV stage
  // poison kills the TL entry
  assign tv_we = v_tl_r & ptag_v_i & ~poison_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tv_r <= 1'b0;
    end else begin
      v_tv_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_we) begin
      paddr_tv_r <= {ptag_i, vaddr_tl_r[page_offset_width_c-1:0]};
      tags_tv_r  <= tags_i;
      valid_tv_r <= valid_i;
      words_tv_r <= words_i;
    end
  end

  assign addr_tag_tv = paddr_tv_r[paddr_width_c-1 -: tag_width_c];
  assign offset_tv   = paddr_tv_r[byte_offset_width_c +: word_offset_width_c];
  assign tv_index_o  = paddr_tv_r[block_offset_width_c +: index_width_c];
  assign tv_valid_o  = valid_tv_r;

  // tag compare
  for (genvar i = 0; i < ways_c; i++) begin : g_hit
    assign hit_v[i] = valid_tv_r[i] & (tags_tv_r[i] == addr_tag_tv);
  end

  assign hit_any = |hit_v;

  // lowest hitting way wins
  always_comb begin
    hit_way = '0;
    for (int i = ways_c - 1; i >= 0; i--) begin
      if (hit_v[i]) begin
        hit_way = way_t'(i);
      end
    end
  end

  // banks are rotated by word offset
  assign word_picked = words_tv_r[hit_way ^ offset_tv];
  assign data_o = paddr_tv_r[byte_offset_width_c-1]
    ? word_picked[instr_width_c +: instr_width_c]
    : word_picked[instr_width_c-1:0];

  assign miss_tv   = v_tv_r & ~hit_any;
  assign data_v_o  = v_tv_r & hit_any;
  assign hit_o     = data_v_o;
  assign hit_way_o = hit_way;

  // block request
  assign cache_req_v_o    = miss_tv & cache_req_ready_i;
  assign cache_req_addr_o = {paddr_tv_r[paddr_width_c-1:block_offset_width_c],
                             {block_offset_width_c{1'b0}}};

  // miss tracker
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_tracker_r <= 1'b0;
    end else if (cache_req_v_o) begin
      miss_tracker_r <= 1'b1;
    end else if (cache_req_complete_i) begin
      miss_tracker_r <= 1'b0;
    end
  end

  assign miss_o        = miss_tv | miss_tracker_r;
  assign vaddr_ready_o = cache_req_ready_i & ~cache_req_v_o & ~miss_tracker_r;

  // the fill engine never places one tag in two ways of a set
  assert property (@(posedge clk_i) disable iff (reset_i) v_tv_r |-> $onehot0(hit_v))
    else $error("multiple ways hit in set %0d", tv_index_o);

  // fetches behind a miss must be poisoned until the fill completes
  assert property (@(posedge clk_i) disable iff (reset_i) cache_req_v_o |-> !miss_tracker_r)
    else $error("block request while a miss is outstanding");

endmodule

// ==== logic/icache_pkg.sv ====
package icache_pkg;

  // cache geometry
  localparam int ways_c              = 4;
  localparam int sets_c              = 16;
  localparam int vaddr_width_c       = 39;
  localparam int paddr_width_c       = 40;
  localparam int page_offset_width_c = 12;

  // field widths derived from the geometry
  localparam int word_width_c          = 64;
  localparam int instr_width_c         = 32;
  localparam int byte_offset_width_c   = 3;
  localparam int word_offset_width_c   = 2;
  localparam int index_width_c         = 4;
  localparam int way_width_c           = 2;
  localparam int block_offset_width_c  = byte_offset_width_c + word_offset_width_c;
  localparam int tag_width_c           = paddr_width_c - block_offset_width_c - index_width_c;
  localparam int ptag_width_c          = paddr_width_c - page_offset_width_c;

  typedef logic [vaddr_width_c-1:0]         vaddr_t;
  typedef logic [ptag_width_c-1:0]          ptag_t;
  typedef logic [paddr_width_c-1:0]         paddr_t;
  typedef logic [index_width_c-1:0]         index_t;
  typedef logic [word_offset_width_c-1:0]   word_offset_t;
  typedef logic [way_width_c-1:0]           way_t;
  typedef logic [tag_width_c-1:0]           tag_t;
  typedef logic [word_width_c-1:0]          word_t;
  typedef logic [ways_c*word_width_c-1:0]   block_t;
  typedef logic [instr_width_c-1:0]         instr_t;
  // one root bit and one leaf bit per way pair
  typedef logic [ways_c-2:0]                lru_t;

  typedef enum logic [1:0] {
    clear_set,
    invalidate_way,
    set_tag
  } tag_op_e;

endpackage
